/* common/aes_key_pkg.sv */
`default_nettype none

package aes_key_pkg;

    // AES-128 fixes all of these
    localparam int NK         = 4;   // key words
    localparam int NUM_ROUNDS = 10;
    localparam int NUM_WORDS  = 44;  // NK * (NUM_ROUNDS + 1)

    typedef logic [31:0]  word_t;      // schedule word / round key column
    typedef logic [127:0] key_t;       // full cipher key or round key
    typedef logic [5:0]   word_idx_t;  // 0 .. NUM_WORDS-1
    typedef logic [3:0]   round_idx_t; // 0 .. NUM_ROUNDS
    typedef logic [1:0]   col_idx_t;   // 0 is the most significant word

    // {round, col} is also the store index 4*round + col
    typedef struct packed {
        round_idx_t round;
        col_idx_t   col;
    } key_sel_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        EXPAND,
        DONE
    } sched_state_t;

    // round constants, entry 0 belongs to round 1
    localparam logic [7:0] RCON_TABLE [NUM_ROUNDS] = '{
        8'h01,
        8'h02,
        8'h04,
        8'h08,
        8'h10,
        8'h20,
        8'h40,
        8'h80,
        8'h1b,
        8'h36
    };

endpackage

`default_nettype wire

/* key_schedule/aes_sbox.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_sbox (
    input  wire logic [7:0] byte_in,
    output logic [7:0]      byte_out
);

    // forward S-box, row n holds inputs 8'hn0 .. 8'hnf
    // element 0 is the leftmost byte of the first row
    localparam logic [0:255][7:0] SBOX = {
        128'h637c777b_f26b6fc5_3001672b_fed7ab76,
        128'hca82c97d_fa5947f0_add4a2af_9ca472c0,
        128'hb7fd9326_363ff7cc_34a5e5f1_71d83115,
        128'h04c723c3_1896059a_071280e2_eb27b275,
        128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84,
        128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf,
        128'hd0efaafb_434d3385_45f9027f_503c9fa8,
        128'h51a3408f_929d38f5_bcb6da21_10fff3d2,
        128'hcd0c13ec_5f974417_c4a77e3d_645d1973,
        128'h60814fdc_222a9088_46eeb814_de5e0bdb,
        128'he0323a0a_4906245c_c2d3ac62_9195e479,
        128'he7c8376d_8dd54ea9_6c56f4ea_657aae08,
        128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a,
        128'h703eb566_4803f60e_613557b9_86c11d9e,
        128'he1f89811_69d98e94_9b1e87e9_ce5528df,
        128'h8ca1890d_bfe64268_41992d0f_b054bb16
    };

    assign byte_out = SBOX[byte_in];

endmodule

`default_nettype wire

/* key_schedule/aes_word_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_word_gen import aes_key_pkg::*; (
    input  wire word_idx_t word_idx,
    input  wire word_t     prev_word, // w[i-1]
    input  wire word_t     back_word, // w[i-4]
    output word_t          new_word
);

    word_t      rot_word;
    word_t      sub_word;
    round_idx_t round;
    logic [7:0] rcon;

    // RotWord, one byte to the left
    assign rot_word = {prev_word[23:0], prev_word[31:24]};

    // SubWord
    for (genvar i = 0; i < 4; i++) begin : g_sub
        aes_sbox sbox_inst (
            .byte_in  (rot_word[8*i +: 8]),
            .byte_out (sub_word[8*i +: 8])
        );
    end

    assign round = word_idx[5:2]; // i / NK
    assign rcon  = (round != 4'd0 && round <= round_idx_t'(NUM_ROUNDS)) ?
                   RCON_TABLE[round - 4'd1] : 8'h00;

    // the transform only applies at the first word of each round key
    assign new_word = back_word ^ ((word_idx[1:0] == 2'b00) ?
                                   (sub_word ^ {rcon, 24'h000000}) : prev_word);

endmodule

`default_nettype wire

/* key_schedule/key_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module key_loader import aes_key_pkg::*; (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  start,      // one-cycle pulse
    input  wire word_t cipher_key, // one key word per cycle after start
    output key_t       key,
    output logic       loading
);

    logic [1:0]       load_cnt;  // which key word arrives next
    word_t [NK-1:0]   key_words; // [NK-1] holds word 0

    assign key = key_words;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            load_cnt <= 2'd0;
            loading  <= 1'b0;
        end else if (start) begin
            load_cnt <= 2'd0; // a new start always restarts the load
            loading  <= 1'b1;
        end else if (loading) begin
            load_cnt <= load_cnt + 2'd1;
            if (load_cnt == 2'd3) begin
                loading <= 1'b0; // fourth word taken
            end
        end
    end

    // ~load_cnt is 3 - load_cnt, so word 0 lands in the top slot
    always_ff @(posedge clk) begin
        if (loading && !start) begin
            key_words[~load_cnt] <= cipher_key;
        end
    end

    // a load window is four cycles long unless a new start restarts it
    loading_window_a: assert property (@(posedge clk) disable iff (reset)
        $rose(loading) ##0 (!start)[*4] |=> !loading)
        else $error("loading did not fall four cycles after it rose");

endmodule

`default_nettype wire

/* key_schedule/key_schedule_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module key_schedule_ctrl import aes_key_pkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     start,
    input  wire logic     loading,
    input  wire key_t     key,
    input  wire key_sel_t sel,
    input  wire word_t    new_word,  // from the word function, same cycle
    output word_idx_t     word_idx,
    output word_t         prev_word,
    output word_t         back_word,
    output word_t         round_key,
    output logic          done
);

    sched_state_t   state;
    word_t          store [NUM_WORDS]; // w[0] .. w[43]
    word_t [NK-1:0] key_words;
    logic           load_key;
    logic           write_word;

    assign key_words = key;

    // start takes priority over everything below
    assign load_key   = !start && state == LOAD && !loading;
    assign write_word = !start && state == EXPAND;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= IDLE;
            word_idx <= word_idx_t'(NK); // keeps the store taps in range
            done     <= 1'b0;
        end else if (start) begin
            state <= LOAD;
            done  <= 1'b0;
        end else begin
            case (state)
                IDLE: state <= IDLE;
                LOAD: begin
                    if (load_key) begin
                        state    <= EXPAND;
                        word_idx <= word_idx_t'(NK);
                    end
                end
                EXPAND: begin
                    if (word_idx == word_idx_t'(NUM_WORDS - 1)) begin
                        state <= DONE; // last word written this cycle
                    end else begin
                        word_idx <= word_idx + 6'd1;
                    end
                end
                DONE: done <= 1'b1; // held until the next start
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_key) begin
            for (int i = 0; i < NK; i++) begin
                store[i] <= key_words[NK - 1 - i];
            end
        end else if (write_word) begin
            store[word_idx] <= new_word;
        end
    end

    assign prev_word = store[word_idx - 6'd1];
    assign back_word = store[word_idx - 6'd4];

    // read port, valid while done is high
    assign round_key = store[{sel.round, sel.col}];

    expand_range_a: assert property (@(posedge clk) disable iff (reset)
        state == EXPAND |-> word_idx >= word_idx_t'(NK) && word_idx < word_idx_t'(NUM_WORDS))
        else $error("word_idx %0d out of range during expansion", word_idx);

    done_busy_a: assert property (@(posedge clk) disable iff (reset)
        (state == LOAD || state == EXPAND) |-> !done)
        else $error("done high while the schedule is being built");

endmodule

`default_nettype wire

/* verilog/aes_key_expand.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_key_expand import aes_key_pkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     start,      // one-cycle pulse, restarts any run
    input  wire word_t    cipher_key, // four words after start, msw first
    input  wire key_sel_t sel,        // round key and column to read
    output word_t         round_key,
    output logic          done
);

    key_t      key;
    logic      loading;
    word_idx_t word_idx;
    word_t     prev_word;
    word_t     back_word;
    word_t     new_word;

    key_loader key_loader_inst (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .cipher_key (cipher_key),
        .key        (key),
        .loading    (loading)
    );

    key_schedule_ctrl key_schedule_ctrl_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .loading   (loading),
        .key       (key),
        .sel       (sel),
        .new_word  (new_word),
        .word_idx  (word_idx),
        .prev_word (prev_word),
        .back_word (back_word),
        .round_key (round_key),
        .done      (done)
    );

    // next word is combinational, written back on the same edge
    aes_word_gen aes_word_gen_inst (
        .word_idx  (word_idx),
        .prev_word (prev_word),
        .back_word (back_word),
        .new_word  (new_word)
    );

endmodule

`default_nettype wire

/* test/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// FIPS-197 appendix A.1 key and two of its round keys, column 0 in the top bits
localparam key_t FIPS_KEY     = 128'h2b7e1516_28aed2a6_abf71588_09cf4f3c;
localparam key_t FIPS_ROUND1  = 128'ha0fafe17_88542cb1_23a33939_2a6c7605;
localparam key_t FIPS_ROUND10 = 128'hd014f9a8_c9ee2589_e13f0cc8_b6630ca6;

// schedule of the all-zero key
localparam key_t ZERO_KEY     = 128'h0;
localparam key_t ZERO_ROUND1  = {4{32'h62636363}};
localparam key_t ZERO_ROUND10 = 128'hb4ef5bcb_3e92e211_23e951cf_6f8f188e;

localparam int DONE_TIMEOUT = 100; // cycles

// key write, forty schedule words, then the done register
localparam int DONE_LATENCY = NUM_WORDS - NK + 2;

// xorshift32 step (13, 17, 5)
function automatic word_t xorshift32(input word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// start pulse, then the four key words on the next four falling edges
task automatic load_key(input key_t k);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    for (int i = 0; i < NK; i++) begin
        check_level("done", 1'b0, done); // cleared by start, low while loading
        cipher_key = k[127 - 32*i -: 32];
        @(negedge clk);
    end
endtask

task automatic wait_done();
    int cycles;
    cycles = 0;
    while (!done && cycles < DONE_TIMEOUT) begin
        @(negedge clk);
        cycles++;
    end
    if (!done) begin
        abort_run("done never rose after the key was loaded");
    end else begin
        // done stays low until the last schedule word is written
        check_word("done latency", word_t'(DONE_LATENCY), word_t'(cycles));
    end
endtask

`endif

/* test/tb_aes_key_expand.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_aes_key_expand import aes_key_pkg::*; ();

    logic     clk;
    logic     reset;
    logic     start;
    word_t    cipher_key;
    key_sel_t sel;
    word_t    round_key;
    logic     done;

    word_t    sched [NUM_WORDS]; // schedule as read back through sel
    word_t    rng;
    key_t     rand_key;

    `include "tb_vectors.svh"

    aes_key_expand aes_key_expand_inst (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .cipher_key (cipher_key),
        .sel        (sel),
        .round_key  (round_key),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        assert (actual == expected) else
            abort_run($sformatf("Fail %s expected %08h got %08h", name, expected, actual));
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        assert (actual === expected) else
            abort_run($sformatf("Fail %s expected %0h got %0h", name, expected, actual));
    endtask

    task automatic make_random_key(output key_t k);
        for (int i = 0; i < NK; i++) begin
            rng = xorshift32(rng);
            k   = {k[95:0], rng};
        end
    endtask

    // sel moves on the falling edge, round_key is sampled one cycle later
    task automatic read_schedule();
        for (int r = 0; r <= NUM_ROUNDS; r++) begin
            for (int c = 0; c < NK; c++) begin
                sel.round = round_idx_t'(r);
                sel.col   = col_idx_t'(c);
                @(negedge clk);
                check_level("done", 1'b1, done);
                sched[NK*r + c] = round_key;
            end
        end
    endtask

    task automatic check_round(input int r, input key_t expected);
        for (int c = 0; c < NK; c++) begin
            check_word($sformatf("round_key[%0d][%0d]", r, c),
                       expected[127 - 32*c -: 32], sched[NK*r + c]);
        end
    endtask

    // w[i] = w[i-4] ^ w[i-1] for every column but the first
    task automatic check_key_rule(input key_t k);
        check_round(0, k);
        for (int r = 1; r <= NUM_ROUNDS; r++) begin
            for (int c = 1; c < NK; c++) begin
                check_word($sformatf("round_key[%0d][%0d]", r, c),
                           sched[NK*(r-1) + c] ^ sched[NK*r + c - 1], sched[NK*r + c]);
            end
        end
    endtask

    initial begin
        reset      = 1'b1;
        start      = 1'b0;
        cipher_key = '0;
        sel        = '0;
        rng        = 32'hc69ea479;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        repeat (3) begin
            @(negedge clk);
            check_level("done", 1'b0, done); // nothing started yet
        end

        load_key(FIPS_KEY);
        wait_done();
        read_schedule();
        check_round(0, FIPS_KEY);
        check_round(1, FIPS_ROUND1);
        check_round(10, FIPS_ROUND10);

        load_key(ZERO_KEY);
        wait_done();
        read_schedule();
        check_round(0, ZERO_KEY);
        check_round(1, ZERO_ROUND1);
        check_round(10, ZERO_ROUND10);

        for (int n = 0; n < 10; n++) begin
            make_random_key(rand_key);
            load_key(rand_key);
            wait_done();
            read_schedule();
            check_key_rule(rand_key);
        end

        // restart halfway through an expansion
        make_random_key(rand_key);
        load_key(rand_key);
        repeat (10) begin
            @(negedge clk);
            check_level("done", 1'b0, done);
        end
        make_random_key(rand_key);
        load_key(rand_key);
        wait_done();
        read_schedule();
        check_key_rule(rand_key);

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+test
common/aes_key_pkg.sv
key_schedule/aes_sbox.sv
key_schedule/aes_word_gen.sv
key_schedule/key_loader.sv
key_schedule/key_schedule_ctrl.sv
verilog/aes_key_expand.sv
test/tb_aes_key_expand.sv

/* run.sh */
#!/bin/sh
# build and run the AES-128 key expansion testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_aes_key_expand

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sources.f --top-module "$TOP" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test OK$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi
